// File: mem_resp_noc.f
+incdir+source
source/mem_resp_noc_pkg.sv
source/mem_resp_packet_encode.sv
source/packet_fifo.sv
source/packet_flit_serializer.sv
source/mem_resp_noc_top.sv
tests/tb_clock_gen.sv
tests/mem_resp_noc_tb.sv

// File: source/mem_resp_noc_params.svh
`ifndef MEM_RESP_NOC_PARAMS_SVH
`define MEM_RESP_NOC_PARAMS_SVH

////////////////////////////////////////////////////////////////////////////
// network widths
////////////////////////////////////////////////////////////////////////////

// mesh coordinate bits
`define MEM_NOC_CORD_WIDTH 4

// concentrator id bits
`define MEM_NOC_CID_WIDTH 2

// packet length in flits minus one
`define MEM_NOC_LEN_WIDTH 4

`define MEM_NOC_FLIT_WIDTH 32 // one flit on the link

////////////////////////////////////////////////////////////////////////////
// memory side
////////////////////////////////////////////////////////////////////////////

`define MEM_ADDR_WIDTH 20

// one 128 bit cache block
`define MEM_BLOCK_WIDTH 128

////////////////////////////////////////////////////////////////////////////
// buffering
////////////////////////////////////////////////////////////////////////////

// default number of whole packets in the fifo
`define PACKET_FIFO_DEPTH 4

`endif

// File: source/mem_resp_noc_pkg.sv
`include "mem_resp_noc_params.svh"

package mem_resp_noc_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // message encodings
  ////////////////////////////////////////////////////////////////////////////

  typedef enum logic [2:0] {
    e_mem_rd    = 3'd0,
    e_mem_wr    = 3'd1,
    e_mem_uc_rd = 3'd2,
    e_mem_uc_wr = 3'd3,
    e_mem_wb    = 3'd4 // 5..7 not used
  } mem_msg_type_e;

  // transfer size in bytes
  typedef enum logic [2:0] {
    e_mem_size_1  = 3'd0,
    e_mem_size_2  = 3'd1,
    e_mem_size_4  = 3'd2,
    e_mem_size_8  = 3'd3,
    e_mem_size_16 = 3'd4
  } mem_size_e;

  ////////////////////////////////////////////////////////////////////////////
  // network fields
  ////////////////////////////////////////////////////////////////////////////

  localparam int mem_noc_reserved_width = 2; // always zero

  typedef logic [`MEM_NOC_CORD_WIDTH-1:0] cord_t;
  typedef logic [`MEM_NOC_CID_WIDTH-1:0]  cid_t;
  typedef logic [`MEM_NOC_LEN_WIDTH-1:0]  len_t;
  typedef logic [`MEM_NOC_FLIT_WIDTH-1:0] flit_t;

  // 154 bit response as it leaves the coherence engine
  typedef struct packed {
    logic [`MEM_BLOCK_WIDTH-1:0] data; // short transfers in the low bytes
    logic [`MEM_ADDR_WIDTH-1:0]  addr;
    mem_size_e                   size;
    mem_msg_type_e               msg_type;
  } mem_resp_s;

  typedef struct packed {
    mem_resp_s                         msg;
    cid_t                              src_cid;
    cord_t                             src_cord;
    logic [mem_noc_reserved_width-1:0] reserved;
  } mem_resp_payload_s;

  // 172 bit wormhole packet with the routing fields at the bottom
  typedef struct packed {
    mem_resp_payload_s payload;
    len_t              len;
    cid_t              cid;
    cord_t             cord;
  } mem_resp_packet_s;

endpackage

// File: source/mem_resp_noc_top.sv
`timescale 1ns/1ps
`include "mem_resp_noc_params.svh"

module mem_resp_noc_top (
  input  logic                        clk_i,
  input  logic                        arst_n_i,
  input  logic                        mem_resp_v_i,
  input  mem_resp_noc_pkg::mem_resp_s mem_resp_i,
  input  mem_resp_noc_pkg::cord_t     src_cord_i,
  input  mem_resp_noc_pkg::cid_t      src_cid_i,
  input  mem_resp_noc_pkg::cord_t     dst_cord_i,
  input  mem_resp_noc_pkg::cid_t      dst_cid_i,
  input  logic                        link_ready_i,
  output mem_resp_noc_pkg::flit_t     flit_o,
  output logic                        flit_v_o,
  output logic                        flit_last_o,
  output logic                        fifo_full_o,
  output logic                        overflow_o
);

  import mem_resp_noc_pkg::*;

  mem_resp_packet_s enc_packet;
  logic             enc_v;
  mem_resp_packet_s head_packet;
  logic             empty;
  logic             pop;

  // response to packet
  mem_resp_packet_encode u_encode (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .mem_resp_v_i (mem_resp_v_i),
    .mem_resp_i   (mem_resp_i),
    .src_cord_i   (src_cord_i),
    .src_cid_i    (src_cid_i),
    .dst_cord_i   (dst_cord_i),
    .dst_cid_i    (dst_cid_i),
    .packet_v_o   (enc_v),
    .packet_o     (enc_packet)
  );

  packet_fifo #(
    .depth_p (`PACKET_FIFO_DEPTH)
  ) u_fifo (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .wr_i        (enc_v),
    .wr_packet_i (enc_packet),
    .rd_i        (pop),
    .rd_packet_o (head_packet),
    .empty_o     (empty),
    .full_o      (fifo_full_o),
    .overflow_o  (overflow_o)
  );

  // packet to flits on the link
  packet_flit_serializer u_serializer (
    .clk_i         (clk_i),
    .arst_n_i      (arst_n_i),
    .empty_i       (empty),
    .head_packet_i (head_packet),
    .link_ready_i  (link_ready_i),
    .pop_o         (pop),
    .flit_o        (flit_o),
    .flit_v_o      (flit_v_o),
    .flit_last_o   (flit_last_o)
  );

endmodule

// File: source/mem_resp_packet_encode.sv
`timescale 1ns/1ps
`include "mem_resp_noc_params.svh"

module mem_resp_packet_encode (
  input  logic                               clk_i,
  input  logic                               arst_n_i,
  input  logic                               mem_resp_v_i,
  input  mem_resp_noc_pkg::mem_resp_s        mem_resp_i,
  input  mem_resp_noc_pkg::cord_t            src_cord_i,
  input  mem_resp_noc_pkg::cid_t             src_cid_i,
  input  mem_resp_noc_pkg::cord_t            dst_cord_i,
  input  mem_resp_noc_pkg::cid_t             dst_cid_i,
  output logic                               packet_v_o,
  output mem_resp_noc_pkg::mem_resp_packet_s packet_o
);

  import mem_resp_noc_pkg::*;

  ////////////////////////////////////////////////////////////////////////////
  // flit counts per transfer size
  ////////////////////////////////////////////////////////////////////////////

  // everything but the data block
  localparam int header_width_lp = $bits(mem_resp_packet_s) - `MEM_BLOCK_WIDTH;
  localparam int flit_width_lp   = `MEM_NOC_FLIT_WIDTH;

  localparam int ack_len_lp =
    (header_width_lp + flit_width_lp - 1) / flit_width_lp - 1;
  localparam int len_1_lp =
    (header_width_lp + 8 * 1 + flit_width_lp - 1) / flit_width_lp - 1;
  localparam int len_2_lp =
    (header_width_lp + 8 * 2 + flit_width_lp - 1) / flit_width_lp - 1;
  localparam int len_4_lp =
    (header_width_lp + 8 * 4 + flit_width_lp - 1) / flit_width_lp - 1;
  localparam int len_8_lp =
    (header_width_lp + 8 * 8 + flit_width_lp - 1) / flit_width_lp - 1;
  localparam int len_16_lp =
    (header_width_lp + 8 * 16 + flit_width_lp - 1) / flit_width_lp - 1;

  localparam int max_len_lp = len_16_lp; // full block is the longest

  mem_resp_payload_s payload_li;
  len_t              data_len_li;
  mem_resp_packet_s  packet_n;

  always_comb begin
    payload_li.msg      = mem_resp_i;
    payload_li.src_cid  = src_cid_i;
    payload_li.src_cord = src_cord_i;
    payload_li.reserved = '0;

    case (mem_resp_i.size)
      e_mem_size_1:  data_len_li = len_t'(len_1_lp);
      e_mem_size_2:  data_len_li = len_t'(len_2_lp);
      e_mem_size_4:  data_len_li = len_t'(len_4_lp);
      e_mem_size_8:  data_len_li = len_t'(len_8_lp);
      e_mem_size_16: data_len_li = len_t'(len_16_lp);
      default:       data_len_li = '0; // bad size goes out as one flit
    endcase

    packet_n.payload = payload_li;
    packet_n.len     = '0;
    packet_n.cid     = dst_cid_i;
    packet_n.cord    = dst_cord_i;

    case (mem_resp_i.msg_type)
      e_mem_rd, e_mem_wr, e_mem_uc_rd: packet_n.len = data_len_li;
      e_mem_uc_wr, e_mem_wb:           packet_n.len = len_t'(ack_len_lp);
      default:                         packet_n     = '0;
    endcase
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      packet_v_o <= 1'b0;
    end else begin
      packet_v_o <= mem_resp_v_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (mem_resp_v_i) begin
      packet_o <= packet_n;
    end
  end

  // the serializer indexes at most six flits
  a_len_bound: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    packet_v_o |-> packet_o.len <= len_t'(max_len_lp));

endmodule

// File: source/packet_fifo.sv
`timescale 1ns/1ps
`include "mem_resp_noc_params.svh"

module packet_fifo #(
  parameter int depth_p = `PACKET_FIFO_DEPTH
) (
  input  logic                               clk_i,
  input  logic                               arst_n_i,
  input  logic                               wr_i,
  input  mem_resp_noc_pkg::mem_resp_packet_s wr_packet_i,
  input  logic                               rd_i,
  output mem_resp_noc_pkg::mem_resp_packet_s rd_packet_o,
  output logic                               empty_o,
  output logic                               full_o,
  output logic                               overflow_o
);

  import mem_resp_noc_pkg::*;

  localparam int ptr_width_lp = (depth_p > 1) ? $clog2(depth_p) : 1;
  localparam int cnt_width_lp = $clog2(depth_p + 1);

  mem_resp_packet_s        mem_r [depth_p];
  logic [ptr_width_lp-1:0] wr_ptr_r;
  logic [ptr_width_lp-1:0] rd_ptr_r;
  logic [cnt_width_lp-1:0] count_r;
  logic                    wr_en;
  logic                    rd_en;

  // wraps at depth_p so any depth works
  function automatic logic [ptr_width_lp-1:0] next_ptr(input logic [ptr_width_lp-1:0] ptr);
    if (ptr == ptr_width_lp'(depth_p - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign full_o      = (count_r == cnt_width_lp'(depth_p));
  assign empty_o     = (count_r == '0);
  assign wr_en       = wr_i && !full_o; // dropped when full
  assign rd_en       = rd_i && !empty_o;
  assign rd_packet_o = mem_r[rd_ptr_r]; // head visible right away

  always_ff @(posedge clk_i) begin
    if (wr_en) begin
      mem_r[wr_ptr_r] <= wr_packet_i;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_r   <= '0;
      rd_ptr_r   <= '0;
      count_r    <= '0;
      overflow_o <= 1'b0;
    end else begin
      if (wr_en) begin
        wr_ptr_r <= next_ptr(wr_ptr_r);
      end
      if (rd_en) begin
        rd_ptr_r <= next_ptr(rd_ptr_r);
      end
      case ({wr_en, rd_en})
        2'b10:   count_r <= count_r + 1'b1;
        2'b01:   count_r <= count_r - 1'b1;
        default: count_r <= count_r;
      endcase
      if (wr_i && full_o) begin
        overflow_o <= 1'b1; // sticky until reset
      end
    end
  end

  // the serializer only pops a head that is there
  a_no_read_empty: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    rd_i |-> !empty_o);

  a_count_bound: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    count_r <= cnt_width_lp'(depth_p));

endmodule

// File: source/packet_flit_serializer.sv
`timescale 1ns/1ps
`include "mem_resp_noc_params.svh"

module packet_flit_serializer (
  input  logic                               clk_i,
  input  logic                               arst_n_i,
  input  logic                               empty_i,
  input  mem_resp_noc_pkg::mem_resp_packet_s head_packet_i,
  input  logic                               link_ready_i,
  output logic                               pop_o,
  output mem_resp_noc_pkg::flit_t            flit_o,
  output logic                               flit_v_o,
  output logic                               flit_last_o
);

  import mem_resp_noc_pkg::*;

  localparam int flit_width_lp   = `MEM_NOC_FLIT_WIDTH;
  localparam int packet_width_lp = $bits(mem_resp_packet_s);
  localparam int num_flits_lp    = (packet_width_lp + flit_width_lp - 1) / flit_width_lp;

  logic                                  busy_r;
  len_t                                  idx_r;
  mem_resp_packet_s                      packet_r;
  logic [num_flits_lp*flit_width_lp-1:0] padded_li;

  ////////////////////////////////////////////////////////////////////////////
  // handshake with fifo and link
  ////////////////////////////////////////////////////////////////////////////

  assign pop_o       = !busy_r && !empty_i;
  assign flit_v_o    = busy_r && link_ready_i; // index holds while stalled
  assign flit_last_o = flit_v_o && (idx_r == packet_r.len);

  // zero above the last packet bit
  always_comb begin
    padded_li = '0;
    padded_li[packet_width_lp-1:0] = packet_r;
  end

  assign flit_o = padded_li[idx_r * flit_width_lp +: flit_width_lp];

  always_ff @(posedge clk_i) begin
    if (pop_o) begin
      packet_r <= head_packet_i;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      busy_r <= 1'b0;
      idx_r  <= '0;
    end else if (pop_o) begin
      busy_r <= 1'b1;
      idx_r  <= '0; // flit 0 goes first
    end else if (flit_v_o) begin
      if (flit_last_o) begin
        busy_r <= 1'b0;
        idx_r  <= '0;
      end else begin
        idx_r <= idx_r + 1'b1;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // checks
  ////////////////////////////////////////////////////////////////////////////

  a_idx_in_range: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    busy_r |-> idx_r <= packet_r.len);

  // no new packet while one is still going out
  a_pop_idle: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    busy_r && !flit_last_o |=> !pop_o);

endmodule

// File: tests/mem_resp_noc_tb.sv
`timescale 1ns/1ps
`include "mem_resp_noc_params.svh"

module mem_resp_noc_tb;

  import mem_resp_noc_pkg::*;

  localparam int max_vec_lp = 64;

  logic      clk_i;
  logic      arst_n_i;
  logic      mem_resp_v_i;
  mem_resp_s mem_resp_i;
  cord_t     src_cord_i;
  cid_t      src_cid_i;
  cord_t     dst_cord_i;
  cid_t      dst_cid_i;
  logic      link_ready_i = 1'b0;
  flit_t     flit_o;
  logic      flit_v_o;
  logic      flit_last_o;
  logic      fifo_full_o;
  logic      overflow_o;

  // one entry per vector line
  logic [2:0]                  vec_type [max_vec_lp];
  logic [2:0]                  vec_size [max_vec_lp];
  logic [`MEM_ADDR_WIDTH-1:0]  vec_addr [max_vec_lp];
  logic [`MEM_BLOCK_WIDTH-1:0] vec_data [max_vec_lp];
  cord_t                       vec_src_cord [max_vec_lp];
  cid_t                        vec_src_cid [max_vec_lp];
  cord_t                       vec_dst_cord [max_vec_lp];
  cid_t                        vec_dst_cid [max_vec_lp];
  len_t                        vec_len [max_vec_lp];
  int                          nvec;

  logic [191:0] exp_q [$]; // packets padded to six flits
  len_t         len_q [$];
  logic [191:0] cur_pkt;
  len_t         cur_len;
  int           flit_idx;
  bit           in_packet;
  int           packets_done;
  int           sent_total;
  int           filled;
  int           ready_mode; // 0 low, 1 high, 2 random
  integer       seed = 83093;
  logic [31:0]  rnd_word;

  tb_clock_gen u_clk (
    .clk_o    (clk_i),
    .arst_n_o (arst_n_i)
  );

  mem_resp_noc_top u_dut (
    .clk_i        (clk_i),
    .arst_n_i     (arst_n_i),
    .mem_resp_v_i (mem_resp_v_i),
    .mem_resp_i   (mem_resp_i),
    .src_cord_i   (src_cord_i),
    .src_cid_i    (src_cid_i),
    .dst_cord_i   (dst_cord_i),
    .dst_cid_i    (dst_cid_i),
    .link_ready_i (link_ready_i),
    .flit_o       (flit_o),
    .flit_v_o     (flit_v_o),
    .flit_last_o  (flit_last_o),
    .fifo_full_o  (fifo_full_o),
    .overflow_o   (overflow_o)
  );

  ////////////////////////////////////////////////////////////////////////////
  // error reporting and checks
  ////////////////////////////////////////////////////////////////////////////

  task automatic report_mismatch(input string msg);
    $display("FAIL at %0t ns: %s", $time, msg);
    $display("SIMULATION FAILED");
    $fatal(1);
  endtask

  task automatic stop_with_reason(input string why);
    $display("%s", why);
    $display("SIMULATION FAILED");
    $fatal(1);
  endtask

  task automatic check_flit(input flit_t exp, input flit_t act, input int pkt, input int idx);
    if (act !== exp) begin
      report_mismatch($sformatf("packet %0d flit %0d expected %h got %h", pkt, idx, exp, act));
    end
  endtask

  task automatic check_len(input len_t exp, input len_t act, input int pkt);
    if (act !== exp) begin
      report_mismatch($sformatf("packet %0d len %0d but %0d flits seen", pkt, exp, act + 1));
    end
  endtask

  task automatic check_last(input logic exp, input logic act, input int pkt, input int idx);
    if (act !== exp) begin
      report_mismatch($sformatf("packet %0d flit %0d flit_last_o expected %b got %b",
                                pkt, idx, exp, act));
    end
  endtask

  task automatic check_level(input logic exp, input logic act, input string name);
    if (act !== exp) begin
      report_mismatch($sformatf("%s expected %b got %b", name, exp, act));
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////////////////////////////////////////

  task automatic load_vectors();
    integer           fd;
    logic [8*256-1:0] line;
    int               n;
    fd = $fopen("tests/mem_resp_noc_vectors.txt", "r");
    if (fd == 0) begin
      stop_with_reason("could not open tests/mem_resp_noc_vectors.txt");
    end
    nvec = 0;
    while (nvec < max_vec_lp && $fgets(line, fd) != 0) begin
      n = $sscanf(line, "%h %h %h %h %h %h %h %h %h", vec_type[nvec], vec_size[nvec],
                  vec_addr[nvec], vec_data[nvec], vec_src_cord[nvec], vec_src_cid[nvec],
                  vec_dst_cord[nvec], vec_dst_cid[nvec], vec_len[nvec]);
      if (n == 9) begin
        nvec++; // comment lines scan short
      end
    end
    $fclose(fd);
    if (nvec < 6) begin
      stop_with_reason("the vectors file holds too few responses");
    end
  endtask

  // expected packet in field order or all zero for a bad type
  function automatic logic [191:0] expected_packet(input int i);
    logic [191:0] pkt;
    pkt = '0;
    if (vec_type[i] <= 3'd4) begin
      pkt[171:0] = {vec_data[i], vec_addr[i], vec_size[i], vec_type[i], vec_src_cid[i],
                    vec_src_cord[i], 2'b00, vec_len[i], vec_dst_cid[i], vec_dst_cord[i]};
    end
    return pkt;
  endfunction

  task automatic send_resp(input int i, input bit accepted);
    @(posedge clk_i);
    mem_resp_v_i <= 1'b1;
    mem_resp_i   <= {vec_data[i], vec_addr[i], vec_size[i], vec_type[i]};
    src_cord_i   <= vec_src_cord[i];
    src_cid_i    <= vec_src_cid[i];
    dst_cord_i   <= vec_dst_cord[i];
    dst_cid_i    <= vec_dst_cid[i];
    if (accepted) begin
      exp_q.push_back(expected_packet(i));
      len_q.push_back(vec_len[i]);
    end
    @(posedge clk_i);
    mem_resp_v_i <= 1'b0;
    @(posedge clk_i); // encoder register, then the fifo write
  endtask

  task automatic wait_room();
    int cycles;
    cycles = 0;
    @(negedge clk_i);
    while (fifo_full_o) begin
      if (cycles == 200) begin
        stop_with_reason("timed out waiting for room in the FIFO");
      end
      @(negedge clk_i);
      cycles++;
    end
  endtask

  task automatic wait_drain(input int target);
    int cycles;
    cycles = 0;
    while (packets_done < target) begin
      if (cycles == 3000) begin
        stop_with_reason("timed out waiting for all packets to leave on the link");
      end
      @(negedge clk_i);
      cycles++;
    end
  endtask

  task automatic wait_reset_release();
    int cycles;
    cycles = 0;
    while (arst_n_i !== 1'b1) begin
      if (cycles == 50) begin
        stop_with_reason("reset was never released");
      end
      @(posedge clk_i);
      cycles++;
    end
  endtask

  task automatic send_all();
    for (int i = 0; i < nvec; i++) begin
      wait_room();
      send_resp(i, 1'b1);
    end
  endtask

  always @(posedge clk_i) begin
    if (ready_mode == 2) begin
      rnd_word = $random(seed);
      link_ready_i <= rnd_word[0];
    end else begin
      link_ready_i <= (ready_mode == 1);
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // flit monitor
  ////////////////////////////////////////////////////////////////////////////

  always @(negedge clk_i) begin
    if (arst_n_i) begin
      if (flit_last_o && !flit_v_o) begin
        report_mismatch("flit_last_o high without flit_v_o");
      end
      if (flit_v_o && !link_ready_i) begin
        report_mismatch("flit_v_o high while link_ready_i low");
      end
      if (flit_v_o) begin
        if (!in_packet) begin
          if (exp_q.size() == 0) begin
            report_mismatch("flit arrived with no packet expected");
          end
          cur_pkt   = exp_q.pop_front();
          cur_len   = len_q.pop_front();
          flit_idx  = 0;
          in_packet = 1'b1;
        end
        check_flit(cur_pkt[flit_idx*32 +: 32], flit_o, packets_done, flit_idx);
        if (flit_last_o) begin
          check_len(cur_len, len_t'(flit_idx), packets_done);
          in_packet = 1'b0;
          packets_done++;
        end else begin
          check_last(flit_idx == int'(cur_len), flit_last_o, packets_done, flit_idx);
          flit_idx++;
        end
      end
    end
  end

  initial begin
    mem_resp_v_i = 1'b0;
    mem_resp_i   = '0;
    src_cord_i   = '0;
    src_cid_i    = '0;
    dst_cord_i   = '0;
    dst_cid_i    = '0;
    ready_mode   = 0;
    packets_done = 0;
    sent_total   = 0;
    in_packet    = 1'b0;
    load_vectors();
    wait_reset_release();
    @(negedge clk_i);
    check_level(1'b0, flit_v_o, "flit_v_o after reset");
    check_level(1'b0, flit_last_o, "flit_last_o after reset");
    check_level(1'b0, fifo_full_o, "fifo_full_o after reset");
    check_level(1'b0, overflow_o, "overflow_o after reset");

    // open link, then a random one with the same responses
    ready_mode = 1;
    send_all();
    sent_total += nvec;
    wait_drain(sent_total);
    ready_mode = 2;
    send_all();
    sent_total += nvec;
    wait_drain(sent_total);

    // stalled link fills the serializer and the fifo
    ready_mode = 0;
    filled     = 0;
    @(negedge clk_i);
    while (!fifo_full_o) begin
      if (filled == `PACKET_FIFO_DEPTH + 1) begin
        report_mismatch($sformatf("fifo_full_o still low after %0d responses", filled));
      end
      send_resp(filled % nvec, 1'b1);
      filled++;
      @(negedge clk_i);
    end
    if (filled != `PACKET_FIFO_DEPTH + 1) begin
      report_mismatch($sformatf("fifo_full_o rose after %0d responses", filled));
    end
    check_level(1'b0, overflow_o, "overflow_o before the extra response");
    send_resp(filled % nvec, 1'b0); // dropped
    @(negedge clk_i);
    check_level(1'b1, overflow_o, "overflow_o after the extra response");
    check_level(1'b1, fifo_full_o, "fifo_full_o after the extra response");
    ready_mode = 1;
    sent_total += filled;
    wait_drain(sent_total);
    repeat (20) @(negedge clk_i); // a stray flit in this window would fail

    if (exp_q.size() != 0) begin
      report_mismatch($sformatf("%0d packets never arrived", exp_q.size()));
    end else begin
      $display("SIMULATION PASSED");
      $finish;
    end
  end

endmodule

// File: tests/mem_resp_noc_vectors.txt
# msg_type size addr data src_cord src_cid dst_cord dst_cid len, all hex
# len is the expected packet length in flits minus one
0 0 01a40 000000000000000000000000000000a5 1 0 6 2 1
0 1 01a42 0000000000000000000000000000c3d2 1 0 6 2 1
0 2 01a44 000000000000000000000000deadbeef 1 0 6 2 2
0 3 01a48 00000000000000000123456789abcdef 1 0 6 2 3
0 4 01a80 0f1e2d3c4b5a69788796a5b4c3d2e1f0 1 0 6 2 5
1 0 3ff01 0000000000000000000000000000005a 2 1 9 3 1
1 1 3ff02 00000000000000000000000000007e81 2 1 9 3 1
1 2 3ff04 00000000000000000000000012345678 2 1 9 3 2
1 3 3ff08 0000000000000000fedcba9876543210 2 1 9 3 3
1 4 3ff10 a5a5a5a55a5a5a5ac3c3c3c33c3c3c3c 2 1 9 3 5
2 0 80000 000000000000000000000000000000ff f 3 0 0 1
2 1 80002 0000000000000000000000000000beef f 3 0 0 1
2 2 80004 00000000000000000000000080000001 f 3 0 0 2
2 3 80008 00000000000000001122334455667788 f 3 0 0 3
2 4 80010 ffffffffffffffffffffffffffffffff f 3 0 0 5
3 3 0c3c0 00000000000000000000000000000000 4 2 a 1 1
4 4 0c400 00000000000000000000000000000000 4 2 a 1 1
5 2 12345 000000000000000000000000cafef00d 7 1 3 2 0
7 0 54321 00000000000000000000000000000011 7 1 3 2 0
0 6 00100 00000000000000000000000000000022 5 0 5 0 0
1 5 00200 00000000000000000000000000000033 5 0 5 0 0

// File: tests/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
  output logic clk_o,
  output logic arst_n_o
);

  localparam int half_period_lp  = 50; // 100 ns clock
  localparam int reset_cycles_lp = 10;

  initial begin
    clk_o    = 1'b0;
    arst_n_o = 1'b0;
    repeat (reset_cycles_lp) @(posedge clk_o);
    arst_n_o <= 1'b1;
  end

  always #half_period_lp clk_o = ~clk_o;

endmodule
